// File: Makefile
# Verilator build and run for the frame encoder testbench

VERILATOR ?= verilator
TOP       ?= tb_frame_encoder
FILELIST  ?= src.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
STIM      ?= bench/frame_stim.txt
VFLAGS    ?= --binary --assert -j 0

SOURCES := $(shell grep -v '^+' $(FILELIST))
BIN     := $(BUILD_DIR)/V$(TOP)

.PHONY: all build run clean

all: run

build: $(BIN)

# Rebuilt only when a source or the file list changes
$(BIN): $(SOURCES) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR)

run: $(BIN) $(STIM)
	./$(BIN) 2>&1 | tee $(LOG)
	@if grep -q "TEST FAILED" $(LOG); then \
		echo "Simulation failed, see $(LOG)"; \
		exit 1; \
	fi
	@if ! grep -q "TEST OK" $(LOG); then \
		echo "Simulation ended without a result, see $(LOG)"; \
		exit 1; \
	fi

clean:
	rm -rf $(BUILD_DIR) $(LOG)

// File: bench/frame_stim.txt
# name car1_angle car2_angle car1_opaque car2_opaque
# Angles are signed decimal, only their two low bits count as quarter turns
upright 0 0 32 32
quarter 1 1 32 32
half 2 2 32 32
three_quarter 3 3 32 32
mixed_0_1 0 1 32 32
mixed_1_2 1 2 32 32
mixed_2_3 2 3 32 32
mixed_3_0 3 0 32 32
neg_one -1 -1 32 32
neg_two -2 -2 32 32
neg_three -3 -3 32 32
neg_four -4 -4 32 32
neg_eight -8 -8 32 32
wrap_four 4 4 32 32
wrap_five_six 5 6 32 32
wrap_seven 7 -7 32 32
minus_one_vs_three -1 3 32 32
three_vs_minus_one 3 -1 32 32
neg_pos_six -6 6 32 32
pos_neg_five 5 -5 32 32
max_min 7 -8 32 32
neg_five_zero -5 0 32 32

// File: bench/tb_frame_encoder.sv
`timescale 1ns/1ns
`default_nettype none

module tb_frame_encoder;

    import frame_pkg::*;

    localparam int N               = IMAGE_SIZE;
    localparam int PIXELS          = N * N;
    localparam int ID_WIDTH        = SRAM_DATA_WIDTH - COLOR_WIDTH;
    localparam int WORDS           = 2 ** SRAM_ADDR_WIDTH;
    localparam int CYCLES_PER_TEST = 200;
    localparam int RESET_CYCLES    = 8;
    localparam string STIM_FILE    = "bench/frame_stim.txt";

    logic                         i_clk;
    logic                         i_rst_n;
    logic                         i_start;
    logic signed [ANG_WIDTH-1:0]  i_car1_angle;
    logic signed [ANG_WIDTH-1:0]  i_car2_angle;
    logic [SRAM_ADDR_WIDTH-1:0]   o_sram_addr;
    logic [SRAM_DATA_WIDTH-1:0]   o_sram_data;
    logic                         o_sram_writing;
    object_id_e                   o_object_id;
    logic [PIXEL_COUNT_WIDTH-1:0] o_pixel_counter;
    logic                         o_opacity;
    logic                         o_opacity_valid;
    logic                         o_done;

    int word_errors   = 0;
    int object_errors = 0;
    int count_errors  = 0;
    int other_errors  = 0;
    int cycle_cnt     = 0;
    int cycle_limit   = CYCLES_PER_TEST;
    int write_idx     = 0;
    int valid_idx     = 0;
    int done_rises    = 0;
    logic done_q      = 1'b0;
    string test_name  = "";
    logic [1:0] quarter [OBJECT_OPACITY_NUM];
    int opaque_cnt [OBJECT_OPACITY_NUM];
    logic [SRAM_DATA_WIDTH-1:0] mem [WORDS];
    logic [SRAM_DATA_WIDTH-1:0] mem_ref [WORDS];
    bit written [WORDS];

    frame_encoder #(
        .IMAGE_SIZE (IMAGE_SIZE)
    ) dut_i (
        .i_clk           (i_clk),
        .i_rst_n         (i_rst_n),
        .i_start         (i_start),
        .i_car1_angle    (i_car1_angle),
        .i_car2_angle    (i_car2_angle),
        .o_sram_addr     (o_sram_addr),
        .o_sram_data     (o_sram_data),
        .o_sram_writing  (o_sram_writing),
        .o_object_id     (o_object_id),
        .o_pixel_counter (o_pixel_counter),
        .o_opacity       (o_opacity),
        .o_opacity_valid (o_opacity_valid),
        .o_done          (o_done)
    );

    initial i_clk = 1'b0;
    always #50 i_clk = ~i_clk;

    always @(posedge i_clk) begin
        cycle_cnt++;
        if (cycle_cnt >= cycle_limit) begin
            $display("Timeout after %0d cycles, the DUT never finished its frame", cycle_cnt);
            $display("TEST FAILED");
            $finish;
        end
    end

    // Source pixel colour with paint only in the middle half of the columns
    function automatic logic [COLOR_WIDTH-1:0] sprite_color(input int obj, input int h,
                                                            input int v);
        if (h < N / 4 || h > 3 * N / 4 - 1)
            return '0;
        if (obj == 0)
            return COLOR_WIDTH'(1 + (h + v) % 7);
        return COLOR_WIDTH'(8 + ((h ^ v) % 8));
    endfunction

    // Colour that lands on output pixel p after q quarter turns
    function automatic logic [COLOR_WIDTH-1:0] rotated_color(input int obj, input int q,
                                                             input int p);
        int h;
        int v;
        h = p % N;
        v = p / N;
        case (q)
            0:       return sprite_color(obj, h, v);
            1:       return sprite_color(obj, v, N - 1 - h);
            2:       return sprite_color(obj, N - 1 - h, N - 1 - v);
            default: return sprite_color(obj, N - 1 - v, h);
        endcase
    endfunction

    function automatic int opaque_total(input int obj, input int q);
        int total;
        total = 0;
        for (int p = 0; p < PIXELS; p++)
            if (rotated_color(obj, q, p) != '0)
                total++;
        return total;
    endfunction

    task automatic check_word(input string what, input logic [SRAM_DATA_WIDTH-1:0] expected,
                              input logic [SRAM_DATA_WIDTH-1:0] actual);
        if (expected !== actual) begin
            word_errors++;
            $display("Error %s: expected %h, actual %h", what, expected, actual);
        end
    endtask

    task automatic check_object(input string what, input object_id_e expected,
                                input object_id_e actual);
        if (expected !== actual) begin
            object_errors++;
            $display("Error %s: expected %s, actual %s", what, expected.name(), actual.name());
        end
    endtask

    task automatic check_count(input string what, input int expected, input int actual);
        if (expected != actual) begin
            count_errors++;
            $display("Error %s: expected %0d, actual %0d", what, expected, actual);
        end
    endtask

    // Outputs only move on rising edges, so the falling edge sees them settled
    always @(negedge i_clk) begin : watch_outputs
        int obj;
        int p;
        if (i_rst_n) begin
            if (o_opacity_valid) begin
                obj = valid_idx / PIXELS;
                p   = valid_idx % PIXELS;
                if (obj < OBJECT_OPACITY_NUM) begin
                    check_count($sformatf("%s opacity car%0d pixel %0d", test_name, obj + 1, p),
                                int'(rotated_color(obj, int'(quarter[obj]), p) != '0),
                                int'(o_opacity));
                    check_count($sformatf("%s pixel counter car%0d pixel %0d", test_name,
                                          obj + 1, p),
                                p, int'(o_pixel_counter));
                    if (o_opacity)
                        opaque_cnt[obj]++;
                end
                valid_idx++;
            end
            if (o_sram_writing) begin
                if (written[o_sram_addr]) begin
                    other_errors++;
                    $display("Address %0d was written twice in %s", o_sram_addr, test_name);
                end
                written[o_sram_addr] = 1'b1;
                mem[o_sram_addr]     = o_sram_data;
                check_object($sformatf("%s write %0d", test_name, write_idx),
                             (write_idx < PIXELS) ? OBJECT_CAR1 : OBJECT_CAR2, o_object_id);
                write_idx++;
            end
            if (o_done && !done_q)
                done_rises++;
            done_q = o_done;
        end
    end

    task automatic run_frame(input string name, input int angle1, input int angle2,
                             input int exp1, input int exp2);
        int region_writes;
        int addr;
        test_name     = name;
        quarter[0]    = 2'(angle1);  // Only the low two bits of an angle count
        quarter[1]    = 2'(angle2);
        write_idx     = 0;
        valid_idx     = 0;
        done_rises    = 0;
        opaque_cnt[0] = 0;
        opaque_cnt[1] = 0;
        for (int a = 0; a < WORDS; a++)
            written[a] = 1'b0;
        @(posedge i_clk);
        #5;
        i_car1_angle = ANG_WIDTH'(angle1);
        i_car2_angle = ANG_WIDTH'(angle2);
        i_start      = 1'b1;
        do @(negedge i_clk); while (!o_done);
        repeat (4) begin
            @(negedge i_clk);
            if (!o_done) begin
                other_errors++;
                $display("o_done dropped while start was still held in %s", name);
            end
        end
        @(posedge i_clk);
        #5;
        i_start = 1'b0;
        do @(negedge i_clk); while (o_done);
        check_count({name, " done rises"}, 1, done_rises);
        check_count({name, " opacity valids"}, OBJECT_OPACITY_NUM * PIXELS, valid_idx);
        check_count({name, " opaque car1"}, exp1, opaque_cnt[0]);
        check_count({name, " opaque car2"}, exp2, opaque_cnt[1]);
        for (int obj = 0; obj < OBJECT_OPACITY_NUM; obj++) begin
            region_writes = 0;
            for (int p = 0; p < PIXELS; p++) begin
                addr = obj * OBJECT_REGION_SIZE + p;
                if (written[addr]) begin
                    region_writes++;
                    check_word($sformatf("%s addr %0d", name, addr),
                               {ID_WIDTH'(obj), rotated_color(obj, int'(quarter[obj]), p)},
                               mem[addr]);
                end
            end
            check_count($sformatf("%s writes to car%0d region", name, obj + 1), PIXELS,
                        region_writes);
        end
        check_count({name, " total writes"}, OBJECT_OPACITY_NUM * PIXELS, write_idx);
    endtask

    initial begin
        int fd;
        int a1;
        int a2;
        int e1;
        int e2;
        string line;
        string name;
        string names [$];
        int ang1_q [$];
        int ang2_q [$];
        int exp1_q [$];
        int exp2_q [$];
        i_rst_n      = 1'b0;
        i_start      = 1'b0;
        i_car1_angle = '0;
        i_car2_angle = '0;
        void'($urandom(32'h2482_38c4));
        fd = $fopen(STIM_FILE, "r");
        if (fd == 0) begin
            other_errors++;
            $display("Could not open %s", STIM_FILE);
        end else begin
            while (!$feof(fd)) begin
                line = "";
                void'($fgets(line, fd));
                if (line.len() > 0 && line.getc(0) != "#" &&
                    $sscanf(line, "%s %d %d %d %d", name, a1, a2, e1, e2) == 5) begin
                    names.push_back(name);
                    ang1_q.push_back(a1);
                    ang2_q.push_back(a2);
                    exp1_q.push_back(e1);
                    exp2_q.push_back(e2);
                end
            end
            $fclose(fd);
        end
        // The random and repeated frames run after one frame per file line
        cycle_limit = (names.size() + 2) * CYCLES_PER_TEST + RESET_CYCLES + 10;
        repeat (RESET_CYCLES) @(posedge i_clk);
        #5;
        i_rst_n = 1'b1;
        foreach (names[i]) begin
            run_frame(names[i], ang1_q[i], ang2_q[i], exp1_q[i], exp2_q[i]);
            if (i == 0)
                mem_ref = mem;  // Image that the repeated frame must reproduce
        end
        a1 = int'($urandom_range(15)) - 8;
        a2 = int'($urandom_range(15)) - 8;
        run_frame($sformatf("random_%0d_%0d", a1, a2), a1, a2,
                  opaque_total(0, a1 & 3), opaque_total(1, a2 & 3));
        if (names.size() > 0) begin
            run_frame({"repeat_", names[0]}, ang1_q[0], ang2_q[0], exp1_q[0], exp2_q[0]);
            for (int a = 0; a < OBJECT_OPACITY_NUM * OBJECT_REGION_SIZE; a++)
                check_word($sformatf("repeat_%s addr %0d", names[0], a), mem_ref[a], mem[a]);
        end else begin
            other_errors++;
            $display("No tests were found in %s", STIM_FILE);
        end
        $display("Errors: word %0d, object %0d, count %0d, other %0d",
                 word_errors, object_errors, count_errors, other_errors);
        if (word_errors + object_errors + count_errors + other_errors == 0)
            $display("TEST OK");
        else
            $display("TEST FAILED");
        $finish;
    end

endmodule

`default_nettype wire

// File: design/frame_encoder.sv
`timescale 1ns/1ns
`default_nettype none

module frame_encoder #(
    parameter int IMAGE_SIZE = frame_pkg::IMAGE_SIZE
) (
    input  wire                                         i_clk,
    input  wire                                         i_rst_n,
    input  wire                                         i_start,
    input  wire  signed [frame_pkg::ANG_WIDTH-1:0]      i_car1_angle,
    input  wire  signed [frame_pkg::ANG_WIDTH-1:0]      i_car2_angle,
    output logic        [frame_pkg::SRAM_ADDR_WIDTH-1:0]   o_sram_addr,
    output logic        [frame_pkg::SRAM_DATA_WIDTH-1:0]   o_sram_data,
    output logic                                        o_sram_writing,
    output frame_pkg::object_id_e                       o_object_id,
    output logic        [frame_pkg::PIXEL_COUNT_WIDTH-1:0] o_pixel_counter,
    output logic                                        o_opacity,
    output logic                                        o_opacity_valid,
    output logic                                        o_done
);

    import frame_pkg::*;

    localparam int PIXELS     = IMAGE_SIZE * IMAGE_SIZE;
    localparam int PROC_WIDTH = $clog2(OBJECT_OPACITY_NUM + 1);
    localparam logic [IMAGE_COOR_WIDTH-1:0] LAST_COOR = IMAGE_COOR_WIDTH'(IMAGE_SIZE - 1);

    frame_state_e                  state_r;
    frame_state_e                  state_w;
    logic [PROC_WIDTH-1:0]         proc_cnt_r;
    logic                          start_rotator_r;
    logic signed [ANG_WIDTH-1:0]   angle_r;
    logic [PIXEL_COUNT_WIDTH-1:0]  pixel_cnt_r;
    logic                          car_last_r;
    logic [COLOR_WIDTH-1:0]        pixel_color;
    logic [IMAGE_COOR_WIDTH-1:0]   h_done;
    logic [IMAGE_COOR_WIDTH-1:0]   v_done;
    logic                          last_pixel;
    logic                          all_cars_done;
    logic                          load_car;

    assign all_cars_done = (proc_cnt_r == PROC_WIDTH'(OBJECT_OPACITY_NUM));
    assign last_pixel    = o_opacity_valid && h_done == LAST_COOR && v_done == LAST_COOR;

    // A new car starts once the previous one has drained and the count has moved on
    assign load_car = (state_r == S_PROC) && !start_rotator_r && !car_last_r && !all_cars_done;

    assign o_object_id     = all_cars_done ? OBJECT_MAP : object_id_e'(proc_cnt_r);
    assign o_pixel_counter = pixel_cnt_r;
    assign o_done          = (state_r == S_DONE);

    always_comb begin
        state_w = state_r;
        case (state_r)
            S_IDLE:  if (i_start) state_w = S_PROC;
            S_PROC:  if (all_cars_done) state_w = S_DONE;
            S_DONE:  if (!i_start) state_w = S_IDLE;  // Done holds until start is released
            default: state_w = S_IDLE;
        endcase
    end

    always_ff @(posedge i_clk or negedge i_rst_n) begin
        if (!i_rst_n) begin
            state_r         <= S_IDLE;
            proc_cnt_r      <= '0;
            start_rotator_r <= 1'b0;
            angle_r         <= '0;
            pixel_cnt_r     <= '0;
            car_last_r      <= 1'b0;
        end else begin
            state_r    <= state_w;
            car_last_r <= last_pixel;

            // Object count moves one cycle after the last valid so the id covers its final write
            if (state_r == S_IDLE)
                proc_cnt_r <= '0;
            else if (car_last_r)
                proc_cnt_r <= proc_cnt_r + 1'b1;

            if (load_car) begin
                start_rotator_r <= 1'b1;
                angle_r         <= (o_object_id == OBJECT_CAR1) ? i_car1_angle : i_car2_angle;
            end else if (last_pixel || state_r != S_PROC) begin
                start_rotator_r <= 1'b0;
            end

            if (state_r == S_IDLE)
                pixel_cnt_r <= '0;
            else if (o_opacity_valid)
                pixel_cnt_r <= (pixel_cnt_r == PIXEL_COUNT_WIDTH'(PIXELS - 1)) ?
                               '0 : pixel_cnt_r + 1'b1;
        end
    end

    image_rotator #(
        .IMAGE_SIZE (IMAGE_SIZE)
    ) image_rotator_i (
        .i_clk               (i_clk),
        .i_rst_n             (i_rst_n),
        .i_start             (start_rotator_r),
        .i_angle             (angle_r),
        .i_object_id         (o_object_id),
        .o_color             (pixel_color),
        .o_opacity           (o_opacity),
        .o_h_to_be_processed (h_done),
        .o_v_to_be_processed (v_done),
        .o_valid             (o_opacity_valid)
    );

    sram_encoder #(
        .IMAGE_SIZE (IMAGE_SIZE)
    ) sram_encoder_i (
        .i_clk           (i_clk),
        .i_rst_n         (i_rst_n),
        .i_valid         (o_opacity_valid),
        .i_color         (pixel_color),
        .i_object_id     (o_object_id),
        .i_pixel_counter (pixel_cnt_r),
        .o_sram_addr     (o_sram_addr),
        .o_sram_data     (o_sram_data),
        .o_sram_writing  (o_sram_writing)
    );

    // An idle frame never starts a burst of SRAM writes
    a_no_write_in_idle: assert property (@(posedge i_clk) disable iff (!i_rst_n)
        (state_r == S_IDLE) |-> !$rose(o_sram_writing));

endmodule

`default_nettype wire

// File: design/frame_pkg.sv
`default_nettype none

package frame_pkg;

    // Sprite geometry
    localparam int IMAGE_SIZE        = 8;
    localparam int IMAGE_COOR_WIDTH  = 3;
    localparam int PIXEL_COUNT_WIDTH = 2 * IMAGE_COOR_WIDTH;

    // Signed angle; only bits [1:0] count, as counter-clockwise quarter turns
    localparam int ANG_WIDTH = 4;

    localparam int COLOR_WIDTH = 4;  // Colour 0 is transparent

    localparam int SRAM_ADDR_WIDTH = 8;
    localparam int SRAM_DATA_WIDTH = 8;

    localparam int OBJECT_OPACITY_NUM = 2;  // Objects that actually get rendered
    localparam int OBJECT_REGION_SIZE = 64;  // SRAM words reserved per object

    typedef enum logic [1:0] {
        OBJECT_CAR1 = 2'd0,
        OBJECT_CAR2 = 2'd1,
        OBJECT_MAP  = 2'd2
    } object_id_e;

    typedef enum logic [1:0] {
        S_IDLE,
        S_PROC,
        S_DONE
    } frame_state_e;

    // First SRAM word of an object's region
    function automatic logic [SRAM_ADDR_WIDTH-1:0] region_base(input object_id_e id);
        return SRAM_ADDR_WIDTH'(int'(id) * OBJECT_REGION_SIZE);
    endfunction

endpackage

`default_nettype wire

// File: design/image_rotator.sv
`timescale 1ns/1ns
`default_nettype none

module image_rotator #(
    parameter int IMAGE_SIZE = frame_pkg::IMAGE_SIZE
) (
    input  wire                                         i_clk,
    input  wire                                         i_rst_n,
    input  wire                                         i_start,
    input  wire  signed [frame_pkg::ANG_WIDTH-1:0]      i_angle,
    input  wire frame_pkg::object_id_e                  i_object_id,
    output logic        [frame_pkg::COLOR_WIDTH-1:0]      o_color,
    output logic                                        o_opacity,
    output logic        [frame_pkg::IMAGE_COOR_WIDTH-1:0] o_h_to_be_processed,
    output logic        [frame_pkg::IMAGE_COOR_WIDTH-1:0] o_v_to_be_processed,
    output logic                                        o_valid
);

    import frame_pkg::*;

    localparam int PIXELS = IMAGE_SIZE * IMAGE_SIZE;
    localparam logic [IMAGE_COOR_WIDTH-1:0] LAST_COOR = IMAGE_COOR_WIDTH'(IMAGE_SIZE - 1);
    localparam int VALID_COUNT_WIDTH = $clog2(PIXELS + 1);

    logic [IMAGE_COOR_WIDTH-1:0]  h_cnt;
    logic [IMAGE_COOR_WIDTH-1:0]  v_cnt;
    logic                         scan_done;
    logic                         issue;
    logic [1:0]                   quarter;
    logic [IMAGE_COOR_WIDTH-1:0]  src_h;
    logic [IMAGE_COOR_WIDTH-1:0]  src_v;
    logic [IMAGE_COOR_WIDTH-1:0]  src_h_q;
    logic [IMAGE_COOR_WIDTH-1:0]  src_v_q;
    logic [IMAGE_COOR_WIDTH-1:0]  h_q;
    logic [IMAGE_COOR_WIDTH-1:0]  v_q;
    logic                         valid_q;
    logic [VALID_COUNT_WIDTH-1:0] valid_count;

    assign issue   = i_start && !scan_done;
    assign quarter = i_angle[1:0];  // Two's complement keeps -1 equal to three quarter turns

    // The raster scan of the output image restarts whenever start drops
    always_ff @(posedge i_clk or negedge i_rst_n) begin
        if (!i_rst_n) begin
            h_cnt     <= '0;
            v_cnt     <= '0;
            scan_done <= 1'b0;
        end else if (!i_start) begin
            h_cnt     <= '0;
            v_cnt     <= '0;
            scan_done <= 1'b0;
        end else if (issue) begin
            if (h_cnt == LAST_COOR) begin
                h_cnt <= '0;
                if (v_cnt == LAST_COOR) begin
                    v_cnt     <= '0;
                    scan_done <= 1'b1;
                end else begin
                    v_cnt <= v_cnt + 1'b1;
                end
            end else begin
                h_cnt <= h_cnt + 1'b1;
            end
        end
    end

    // Inverse rotation pulls each output pixel from the source pixel that lands on it
    always_comb begin
        case (quarter)
            2'd0: begin
                src_h = h_cnt;
                src_v = v_cnt;
            end
            2'd1: begin
                src_h = v_cnt;
                src_v = LAST_COOR - h_cnt;
            end
            2'd2: begin
                src_h = LAST_COOR - h_cnt;
                src_v = LAST_COOR - v_cnt;
            end
            default: begin
                src_h = LAST_COOR - v_cnt;
                src_v = h_cnt;
            end
        endcase
    end

    always_ff @(posedge i_clk or negedge i_rst_n) begin
        if (!i_rst_n) begin
            valid_q <= 1'b0;
            o_valid <= 1'b0;
        end else begin
            valid_q <= issue;    // Address stage
            o_valid <= valid_q;  // ROM read stage
        end
    end

    always_ff @(posedge i_clk) begin
        src_h_q             <= src_h;
        src_v_q             <= src_v;
        h_q                 <= h_cnt;
        v_q                 <= v_cnt;
        o_h_to_be_processed <= h_q;
        o_v_to_be_processed <= v_q;
    end

    sprite_rom #(
        .IMAGE_SIZE (IMAGE_SIZE)
    ) sprite_rom_i (
        .i_clk       (i_clk),
        .i_object_id (i_object_id),
        .i_h         (src_h_q),
        .i_v         (src_v_q),
        .o_color     (o_color)
    );

    assign o_opacity = (o_color != '0);

    always_ff @(posedge i_clk or negedge i_rst_n) begin
        if (!i_rst_n)
            valid_count <= '0;
        else if (!i_start)
            valid_count <= '0;
        else if (o_valid)
            valid_count <= valid_count + 1'b1;
    end

    // One start level yields at most one full image worth of pixels
    a_valid_bound: assert property (@(posedge i_clk) disable iff (!i_rst_n)
        (i_start && o_valid) |-> (valid_count < PIXELS));

endmodule

`default_nettype wire

// File: design/sprite_rom.sv
`timescale 1ns/1ns
`default_nettype none

module sprite_rom #(
    parameter int IMAGE_SIZE = frame_pkg::IMAGE_SIZE
) (
    input  wire                                    i_clk,
    input  wire frame_pkg::object_id_e             i_object_id,
    input  wire  [frame_pkg::IMAGE_COOR_WIDTH-1:0] i_h,
    input  wire  [frame_pkg::IMAGE_COOR_WIDTH-1:0] i_v,
    output logic [frame_pkg::COLOR_WIDTH-1:0]      o_color
);

    import frame_pkg::*;

    localparam int PIXELS = IMAGE_SIZE * IMAGE_SIZE;

    // Both cars share one body band in the middle half of the columns
    function automatic logic [COLOR_WIDTH-1:0] pixel_color(
        input int obj,
        input int h,
        input int v
    );
        logic [COLOR_WIDTH-1:0] color;
        color = '0;
        if (h >= IMAGE_SIZE / 4 && h <= 3 * IMAGE_SIZE / 4 - 1) begin
            if (obj == int'(OBJECT_CAR1))
                color = COLOR_WIDTH'(1 + (h + v) % 7);  // Diagonal stripes in 1..7
            else
                color = COLOR_WIDTH'(8 + ((h ^ v) % 8));  // Checker shades in 8..15
        end
        return color;
    endfunction

    logic [COLOR_WIDTH-1:0] sprite [OBJECT_OPACITY_NUM][PIXELS];

    // Contents are laid out row by row with h running fastest
    for (genvar obj = 0; obj < OBJECT_OPACITY_NUM; obj++) begin : g_obj
        for (genvar v = 0; v < IMAGE_SIZE; v++) begin : g_row
            for (genvar h = 0; h < IMAGE_SIZE; h++) begin : g_col
                assign sprite[obj][v * IMAGE_SIZE + h] = pixel_color(obj, h, v);
            end
        end
    end

    always_ff @(posedge i_clk) begin
        case (i_object_id)
            OBJECT_CAR1: o_color <= sprite[0][{i_v, i_h}];
            OBJECT_CAR2: o_color <= sprite[1][{i_v, i_h}];
            default:     o_color <= '0;  // No sprite stored for the map
        endcase
    end

endmodule

`default_nettype wire

// File: design/sram_encoder.sv
`timescale 1ns/1ns
`default_nettype none

module sram_encoder #(
    parameter int IMAGE_SIZE = frame_pkg::IMAGE_SIZE
) (
    input  wire                                      i_clk,
    input  wire                                      i_rst_n,
    input  wire                                      i_valid,
    input  wire  [frame_pkg::COLOR_WIDTH-1:0]        i_color,
    input  wire frame_pkg::object_id_e               i_object_id,
    input  wire  [frame_pkg::PIXEL_COUNT_WIDTH-1:0]  i_pixel_counter,
    output logic [frame_pkg::SRAM_ADDR_WIDTH-1:0]    o_sram_addr,
    output logic [frame_pkg::SRAM_DATA_WIDTH-1:0]    o_sram_data,
    output logic                                     o_sram_writing
);

    import frame_pkg::*;

    localparam int PIXELS         = IMAGE_SIZE * IMAGE_SIZE;
    localparam int ID_FIELD_WIDTH = SRAM_DATA_WIDTH - COLOR_WIDTH;

    logic [SRAM_ADDR_WIDTH-1:0] word_addr;
    logic [SRAM_DATA_WIDTH-1:0] word_data;

    assign word_addr = region_base(i_object_id) + SRAM_ADDR_WIDTH'(i_pixel_counter);

    // Object id in the upper nibble and colour in the lower one
    assign word_data = {ID_FIELD_WIDTH'(i_object_id), i_color};

    always_ff @(posedge i_clk or negedge i_rst_n) begin
        if (!i_rst_n)
            o_sram_writing <= 1'b0;
        else
            o_sram_writing <= i_valid;  // One word per valid since nothing can stall
    end

    always_ff @(posedge i_clk) begin
        if (i_valid) begin
            o_sram_addr <= word_addr;
            o_sram_data <= word_data;
        end
    end

    // Every word lands inside the region of a rendered object and within its image
    a_addr_in_region: assert property (@(posedge i_clk) disable iff (!i_rst_n)
        i_valid |=>
            (o_sram_addr < SRAM_ADDR_WIDTH'(OBJECT_OPACITY_NUM * OBJECT_REGION_SIZE)) &&
            ((o_sram_addr - region_base($past(i_object_id))) < PIXELS));

endmodule

`default_nettype wire

// File: src.f
design/frame_pkg.sv
design/sprite_rom.sv
design/image_rotator.sv
design/sram_encoder.sv
design/frame_encoder.sv
bench/tb_frame_encoder.sv
